/* compile.f */
recorder_pkg.sv
sample_tick_gen.sv
audio_ram.sv
recorder.sv
pwm_dac.sv
recorder_top.sv
tb_recorder.sv

/* Makefile */
# Verilator flow for the echo recorder

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_recorder -o Vtb_recorder

run: build
	./obj_dir/Vtb_recorder | tee sim.log
	@grep -q "Testbench passed" sim.log || (echo "Simulation did not pass"; exit 1)

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module recorder_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* tb_recorder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_recorder;

  import recorder_pkg::*;

  localparam int SAMPLE_PERIOD = 8;
  localparam int ADDR_W        = 8;
  localparam int ECHO_DELAY_1  = 3;
  localparam int ECHO_DELAY_2  = 6;
  localparam int DEPTH         = 2 ** ADDR_W;

  logic    clk_in;
  logic    rst_in;
  sample_t audio_in;
  logic    record_in;
  logic    sample_strobe;
  sample_t signal_out;
  sample_t echo_out;
  logic    pwm_out;

  // Stimulus table, one row per sample strobe
  bit      tab_rec [$];
  sample_t tab_smp [$];

  integer seed = 22886;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;

  // Reference model state
  int model_mem [DEPTH];
  int m_rec_addr = 0;
  int m_clip_len = 0;
  int m_play_addr = 0;
  int exp_sig = 0;
  int exp_echo = 0;
  bit sat_hi_seen = 0;
  bit sat_lo_seen = 0;

  recorder_top #(
    .SAMPLE_PERIOD(SAMPLE_PERIOD),
    .ADDR_W       (ADDR_W),
    .ECHO_DELAY_1 (ECHO_DELAY_1),
    .ECHO_DELAY_2 (ECHO_DELAY_2)
  ) UUT (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .audio_in     (audio_in),
    .record_in    (record_in),
    .sample_strobe(sample_strobe),
    .signal_out   (signal_out),
    .echo_out     (echo_out),
    .pwm_out      (pwm_out)
  );

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  always @(posedge clk_in) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic signed [31:0] actual,
                             input logic signed [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_row(input bit rec, input int smp);
    tab_rec.push_back(rec);
    tab_smp.push_back(sample_t'(smp));
  endtask

  task automatic build_table();
    repeat (3) add_row(1'b0, $random(seed)); // Nothing recorded yet
    repeat (10) add_row(1'b1, $random(seed));
    repeat (25) add_row(1'b0, $random(seed)); // Over two loops of clip 1
    // Large values push the mixer into both clamps
    repeat (8) add_row(1'b1, 120);
    repeat (8) add_row(1'b1, -120);
    repeat (20) add_row(1'b0, 0);
    repeat (5) add_row(1'b1, $random(seed)); // Shorter clip replaces the last
    repeat (12) add_row(1'b0, 0);
    add_row(1'b1, 50); // Single sample, so playback holds a steady level
    repeat (6) add_row(1'b0, 0);
  endtask

  // Record and playback rules applied in software
  task automatic model_step(input bit rec, input int smp);
    int main_v;
    int e1;
    int e2;
    int sum;
    if (rec) begin
      if (m_rec_addr < DEPTH) begin
        model_mem[m_rec_addr] = smp;
        m_rec_addr++;
        m_clip_len = m_rec_addr;
      end
      m_play_addr = 0;
    end else begin
      m_rec_addr = 0;
      if (m_clip_len == 0) begin
        exp_sig  = 0;
        exp_echo = 0;
      end else begin
        main_v = model_mem[m_play_addr];
        e1 = (m_play_addr >= ECHO_DELAY_1) ? model_mem[m_play_addr - ECHO_DELAY_1] : 0;
        e2 = (m_play_addr >= ECHO_DELAY_2) ? model_mem[m_play_addr - ECHO_DELAY_2] : 0;
        sum = main_v + (e1 >>> 1) + (e2 >>> 2);
        if (sum > SAMPLE_MAX) begin
          sum = SAMPLE_MAX;
          sat_hi_seen = 1'b1;
        end else if (sum < SAMPLE_MIN) begin
          sum = SAMPLE_MIN;
          sat_lo_seen = 1'b1;
        end
        exp_sig  = main_v;
        exp_echo = sum;
        m_play_addr = (m_play_addr + 1 >= m_clip_len) ? 0 : m_play_addr + 1;
      end
    end
  endtask

  // Returns on the rising edge that consumes the strobe
  task automatic wait_strobe();
    while (!sample_strobe) @(negedge clk_in);
    @(posedge clk_in);
  endtask

  initial begin
    int high_cnt;
    int quiet_cycles;
    int last_strobe;
    rst_in    <= 1'b1;
    record_in <= 1'b0;
    audio_in  <= '0;
    build_table();
    cycle_limit = tab_rec.size() * SAMPLE_PERIOD + 4 * 256 + 100;

    repeat (2) @(posedge clk_in);
    rst_in    <= 1'b0;
    record_in <= tab_rec[0];
    audio_in  <= tab_smp[0];

    // Quiet outputs until the first strobe
    quiet_cycles = 0;
    last_strobe  = 0;
    @(negedge clk_in);
    while (!sample_strobe) begin
      check_value("signal_out", signal_out, 0);
      check_value("echo_out", echo_out, 0);
      check_value("pwm_out", pwm_out, 0);
      quiet_cycles++;
      @(negedge clk_in);
    end
    check_value("cycles to first sample_strobe", quiet_cycles, SAMPLE_PERIOD);

    for (int i = 0; i < tab_rec.size(); i++) begin
      wait_strobe();
      if (i > 0) begin
        check_value("sample_strobe period", cycle_cnt - last_strobe, SAMPLE_PERIOD);
      end
      last_strobe = cycle_cnt;
      if (i + 1 < tab_rec.size()) begin
        record_in <= tab_rec[i + 1];
        audio_in  <= tab_smp[i + 1];
      end
      model_step(tab_rec[i], tab_smp[i]);
      repeat (5) @(negedge clk_in); // Outputs load at strobe + 4
      check_value("signal_out", signal_out, exp_sig);
      check_value("echo_out", echo_out, exp_echo);
    end

    // Last row keeps playing the one-sample clip
    repeat (300) @(negedge clk_in);
    high_cnt = 0;
    repeat (256) begin
      @(negedge clk_in);
      if (pwm_out) high_cnt++;
    end
    check_value("echo_out", echo_out, exp_echo);
    check_value("pwm_out high cycles", high_cnt, exp_echo + 128);

    if (!sat_hi_seen || !sat_lo_seen) begin
      $display("The stimulus never drove the echo mix into both clamp limits");
      $display("Testbench failed");
      $fatal(1, "saturation not exercised");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* recorder_top.sv */
`timescale 1ns/1ps
`default_nettype none

module recorder_top #(
  parameter int SAMPLE_PERIOD = 8,
  parameter int ADDR_W        = 8,
  parameter int ECHO_DELAY_1  = 3,
  parameter int ECHO_DELAY_2  = 6
) (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  recorder_pkg::sample_t audio_in,
  input  logic                  record_in,
  output logic                  sample_strobe,
  output recorder_pkg::sample_t signal_out,
  output recorder_pkg::sample_t echo_out,
  output logic                  pwm_out
);

  import recorder_pkg::*;

  logic [ADDR_W-1:0] mem_addr;
  logic              mem_we;
  sample_t           mem_wdata;
  sample_t           mem_rdata;

  sample_tick_gen #(
    .SAMPLE_PERIOD(SAMPLE_PERIOD)
  ) tick_gen (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .sample_strobe(sample_strobe)
  );

  recorder #(
    .ADDR_W      (ADDR_W),
    .ECHO_DELAY_1(ECHO_DELAY_1),
    .ECHO_DELAY_2(ECHO_DELAY_2)
  ) rec (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .sample_strobe(sample_strobe),
    .record_in    (record_in),
    .audio_in     (audio_in),
    .mem_addr     (mem_addr),
    .mem_we       (mem_we),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .signal_out   (signal_out),
    .echo_out     (echo_out)
  );

  // Clip buffer, kept beside the recorder for clean inference
  audio_ram #(
    .ADDR_W(ADDR_W)
  ) audio_buffer (
    .clk_in(clk_in),
    .addr  (mem_addr),
    .we    (mem_we),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

  pwm_dac dac (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .level  (echo_out),
    .pwm_out(pwm_out)
  );

endmodule

`default_nettype wire

/* pwm_dac.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_dac (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  recorder_pkg::sample_t level,
  output logic                  pwm_out
);

  import recorder_pkg::*;

  logic [SAMPLE_W-1:0] frame_cnt;
  logic [SAMPLE_W-1:0] duty;
  logic [SAMPLE_W-1:0] level_ob;

  // Two's complement to offset binary, i.e. level + 128
  assign level_ob = {~level[SAMPLE_W-1], level[SAMPLE_W-2:0]};

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      frame_cnt <= '0;
      duty      <= '0;
    end else begin
      frame_cnt <= frame_cnt + 1'b1;
      // Duty only changes on a frame boundary
      if (frame_cnt == '1) begin
        duty <= level_ob;
      end
    end
  end

  // High for the first duty clocks of each frame
  assign pwm_out = (frame_cnt < duty);

endmodule

`default_nettype wire

/* recorder.sv */
`timescale 1ns/1ps
`default_nettype none

module recorder #(
  parameter int ADDR_W       = 8,
  parameter int ECHO_DELAY_1 = 3,
  parameter int ECHO_DELAY_2 = 6
) (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  sample_strobe,
  input  logic                  record_in,
  input  recorder_pkg::sample_t audio_in,
  output logic [ADDR_W-1:0]     mem_addr,
  output logic                  mem_we,
  output recorder_pkg::sample_t mem_wdata,
  input  recorder_pkg::sample_t mem_rdata,
  output recorder_pkg::sample_t signal_out,
  output recorder_pkg::sample_t echo_out
);

  import recorder_pkg::*;

  localparam logic [ADDR_W-1:0] TAP1_DIST = ADDR_W'(ECHO_DELAY_1);
  localparam logic [ADDR_W-1:0] TAP2_DIST = ADDR_W'(ECHO_DELAY_2);

  play_state_t state;

  logic [ADDR_W:0]   record_addr; // Top bit set once the RAM is full
  logic [ADDR_W:0]   clip_len;
  logic [ADDR_W-1:0] playback_addr;

  logic rec_full;
  logic clip_empty;
  logic last_sample;
  logic tap1_ok;
  logic tap2_ok;

  sample_t main_q;
  sample_t echo1_q;
  sample_t echo2_val;
  sample_t mix_sat;

  logic signed [SAMPLE_W+1:0] mix_sum; // Headroom for three terms

  assign rec_full    = record_addr[ADDR_W];
  assign clip_empty  = (clip_len == '0);
  assign last_sample = ({1'b0, playback_addr} + 1'b1 >= clip_len);

  // Taps reaching before the clip start read as silence
  assign tap1_ok = (playback_addr >= TAP1_DIST);
  assign tap2_ok = (playback_addr >= TAP2_DIST);

  // Writes happen right in the strobe cycle
  assign mem_we    = sample_strobe && record_in && !rec_full;
  assign mem_wdata = audio_in;

  always_comb begin
    case (state)
      READ_MAIN:  mem_addr = playback_addr;
      READ_ECHO1: mem_addr = playback_addr - TAP1_DIST;
      READ_ECHO2: mem_addr = playback_addr - TAP2_DIST;
      default:    mem_addr = record_addr[ADDR_W-1:0]; // IDLE and MIX
    endcase
  end

  // Tap 2 is used straight off the RAM in MIX
  assign echo2_val = tap2_ok ? mem_rdata : sample_t'(0);
  assign mix_sum   = main_q + (echo1_q >>> 1) + (echo2_val >>> 2);

  always_comb begin
    if (mix_sum > SAMPLE_MAX) begin
      mix_sat = sample_t'(SAMPLE_MAX);
    end else if (mix_sum < SAMPLE_MIN) begin
      mix_sat = sample_t'(SAMPLE_MIN);
    end else begin
      mix_sat = mix_sum[SAMPLE_W-1:0];
    end
  end

  // Read data lags the address by one clock
  always_ff @(posedge clk_in) begin
    if (state == READ_ECHO1) begin
      main_q <= mem_rdata;
    end
    if (state == READ_ECHO2) begin
      echo1_q <= tap1_ok ? mem_rdata : sample_t'(0);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state         <= IDLE;
      record_addr   <= '0;
      clip_len      <= '0;
      playback_addr <= '0;
      signal_out    <= '0;
      echo_out      <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (sample_strobe && record_in) begin
            playback_addr <= '0;
            if (!rec_full) begin
              record_addr <= record_addr + 1'b1;
              clip_len    <= record_addr + 1'b1;
            end
          end else if (sample_strobe) begin
            record_addr <= '0; // Next take starts over
            state       <= READ_MAIN;
          end
        end
        READ_MAIN:  state <= READ_ECHO1;
        READ_ECHO1: state <= READ_ECHO2;
        READ_ECHO2: state <= MIX;
        MIX: begin
          state <= IDLE;
          if (clip_empty) begin
            signal_out <= '0;
            echo_out   <= '0;
          end else begin
            signal_out    <= main_q;
            echo_out      <= mix_sat;
            playback_addr <= last_sample ? '0 : playback_addr + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Sample period too short for a full read pass
  a_strobe_in_idle: assert property (
    @(posedge clk_in) disable iff (rst_in) sample_strobe |-> state == IDLE
  ) else $error("sample strobe arrived during a playback pass");

  a_we_on_strobe: assert property (
    @(posedge clk_in) disable iff (rst_in) mem_we |-> sample_strobe && state == IDLE
  ) else $error("RAM write outside a record strobe");

  a_tap_order: assert property (
    @(posedge clk_in) ECHO_DELAY_2 > ECHO_DELAY_1
  ) else $error("second echo tap must be further back than the first");

endmodule

`default_nettype wire

/* audio_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_ram #(
  parameter int ADDR_W = 8
) (
  input  logic                  clk_in,
  input  logic [ADDR_W-1:0]     addr,
  input  logic                  we,
  input  recorder_pkg::sample_t wdata,
  output recorder_pkg::sample_t rdata
);

  import recorder_pkg::*;

  localparam int DEPTH = 2 ** ADDR_W;

  sample_t mem [DEPTH];

  // Single port, one address for both write and read
  always_ff @(posedge clk_in) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Read-first, so a write cycle returns the old word
  always_ff @(posedge clk_in) begin
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

/* sample_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_tick_gen #(
  parameter int SAMPLE_PERIOD = 8
) (
  input  logic clk_in,
  input  logic rst_in,
  output logic sample_strobe
);

  localparam int CNT_W = $clog2(SAMPLE_PERIOD);
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(SAMPLE_PERIOD - 1);

  logic [CNT_W-1:0] count;

  // Stands in for the codec sample-rate enable
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      count         <= RELOAD;
      sample_strobe <= 1'b0;
    end else if (count == '0) begin
      count         <= RELOAD;
      sample_strobe <= 1'b1; // One clock wide
    end else begin
      count         <= count - 1'b1;
      sample_strobe <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* recorder_pkg.sv */
`default_nettype none

package recorder_pkg;

  // Audio sample format
  localparam int SAMPLE_W = 8;

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Clamp limits for the echo mixer
  localparam int SAMPLE_MAX = 2 ** (SAMPLE_W - 1) - 1;
  localparam int SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));

  // Playback sequence, one pass per sample strobe
  typedef enum logic [2:0] {
    IDLE,       // Wait for strobe
    READ_MAIN,  // Main address on the RAM
    READ_ECHO1, // Main word back, tap 1 address out
    READ_ECHO2, // Tap 1 word back, tap 2 address out
    MIX         // Tap 2 word back, outputs load
  } play_state_t;

endpackage

`default_nettype wire
